//--- hw/cl_consts.svh
`ifndef CL_CONSTS_SVH
`define CL_CONSTS_SVH

// Memory port geometry
`define CL_ADDR_W       16
`define CL_DATA_W       32
`define CL_STRB_W       (`CL_DATA_W / 8)

// Requests in flight between arbiter and memory
`define CL_OUTSTANDING  4

// Response codes, AXI style
`define CL_RESP_OKAY    2'd0
`define CL_RESP_SLVERR  2'd2

`endif

//--- hw/cl_mem_pkg.sv
`include "cl_consts.svh"

package cl_mem_pkg;

  //------------------------------
  // Request channel
  //------------------------------

  // Single beat, read or write
  typedef struct packed {
    logic                  write;
    logic [`CL_ADDR_W-1:0] addr;
    logic [`CL_DATA_W-1:0] wdata;   // don't care for reads
    logic [`CL_STRB_W-1:0] wstrb;
  } mem_req_t;

  //------------------------------
  // Response channel
  //------------------------------

  // Zero rdata on a write
  typedef struct packed {
    logic [`CL_DATA_W-1:0] rdata;
    logic [1:0]            resp;
  } mem_rsp_t;

endpackage

//--- hw/cl_reset_flr.sv
`timescale 1ns/1ps

module cl_reset_flr (
  input  logic clk,
  input  logic pipe_rst_n,
  input  logic flr_assert,
  output logic sync_rst_n,
  output logic flr_done
);

  logic pre_sync_rst_n;
  logic flr_assert_q;

  // Two-flop internal reset
  always_ff @(posedge clk)
    if (!pipe_rst_n)
    begin
      pre_sync_rst_n <= 1'b0;
      sync_rst_n     <= 1'b0;
    end
    else
    begin
      pre_sync_rst_n <= 1'b1;
      sync_rst_n     <= pre_sync_rst_n;
    end

  // FLR responder pulses done every other cycle while asserted
  always_ff @(posedge clk)
    if (!sync_rst_n)
    begin
      flr_assert_q <= 1'b0;
      flr_done     <= 1'b0;
    end
    else
    begin
      flr_assert_q <= flr_assert;
      flr_done     <= flr_assert_q && !flr_done;
    end

  // New FLR request is answered two cycles later
  a_flr_done_latency: assert property (@(posedge clk) disable iff (!sync_rst_n)
    $rose(flr_assert) |-> ##2 flr_done);

endmodule

//--- hw/cl_reg_slice.sv
`timescale 1ns/1ps

module cl_reg_slice import cl_mem_pkg::*; #(
  parameter type chan_t = mem_req_t
) (
  input  logic  clk,
  input  logic  sync_rst_n,

  input  chan_t in_data,
  input  logic  in_valid,
  output logic  in_ready,

  output chan_t out_data,
  output logic  out_valid,
  input  logic  out_ready
);

  chan_t main_data;
  chan_t skid_data;
  logic  main_valid;
  logic  skid_valid;
  logic  in_fire;
  logic  main_free;

  // Ready comes straight from a flop
  assign in_ready  = !skid_valid;
  assign in_fire   = in_valid && in_ready;
  // Main stage drains or is empty this cycle
  assign main_free = out_ready || !main_valid;

  assign out_data  = main_data;
  assign out_valid = main_valid;

  //------------------------------
  // Control
  //------------------------------
  always_ff @(posedge clk)
    if (!sync_rst_n)
    begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end
    else if (main_free)
    begin
      // Skid holds the older item, so it goes first
      main_valid <= skid_valid || in_fire;
      skid_valid <= 1'b0;
    end
    else if (in_fire)
    begin
      skid_valid <= 1'b1;
    end

  //------------------------------
  // Payload
  //------------------------------
  always_ff @(posedge clk)
    if (main_free)
    begin
      if (skid_valid)
        main_data <= skid_data;
      else if (in_fire)
        main_data <= in_data;
    end
    else if (in_fire)
    begin
      skid_data <= in_data;
    end

  // Stalled output must not change under the consumer
  a_out_stable: assert property (@(posedge clk) disable iff (!sync_rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- hw/cl_mem_arbiter.sv
`timescale 1ns/1ps
`include "cl_consts.svh"

module cl_mem_arbiter import cl_mem_pkg::*; (
  input  logic     clk,
  input  logic     sync_rst_n,

  // Host requester
  input  mem_req_t host_req,
  input  logic     host_req_valid,
  output logic     host_req_ready,
  output mem_rsp_t host_rsp,
  output logic     host_rsp_valid,
  input  logic     host_rsp_ready,

  // Accelerator requester
  input  mem_req_t acc_req,
  input  logic     acc_req_valid,
  output logic     acc_req_ready,
  output mem_rsp_t acc_rsp,
  output logic     acc_rsp_valid,
  input  logic     acc_rsp_ready,

  // Memory side
  output mem_req_t mem_req,
  output logic     mem_req_valid,
  input  logic     mem_req_ready,
  input  mem_rsp_t mem_rsp,
  input  logic     mem_rsp_valid,
  output logic     mem_rsp_ready
);

  localparam int DEPTH = `CL_OUTSTANDING;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic             last_acc;
  logic             pick_acc;
  logic             req_fire;
  logic             rsp_fire;
  logic             head_acc;
  logic             q_full;
  logic [DEPTH-1:0] src_q;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] q_count;

  //------------------------------
  // Request merge
  //------------------------------

  // On a tie the previous winner yields
  always_comb
    if (host_req_valid && acc_req_valid)
      pick_acc = !last_acc;
    else
      pick_acc = acc_req_valid;

  assign q_full = (q_count == CNT_W'(DEPTH));

  assign mem_req        = pick_acc ? acc_req : host_req;
  assign mem_req_valid  = (host_req_valid || acc_req_valid) && !q_full;
  assign host_req_ready = mem_req_ready && !q_full && !pick_acc;
  assign acc_req_ready  = mem_req_ready && !q_full && pick_acc;

  assign req_fire = mem_req_valid && mem_req_ready;

  always_ff @(posedge clk)
    if (!sync_rst_n)
      last_acc <= 1'b0;
    else if (req_fire)
      last_acc <= pick_acc;

  //------------------------------
  // Return routing
  //------------------------------

  // Memory answers in order, so the queue head owns the response
  assign head_acc = src_q[rd_ptr];

  assign host_rsp       = mem_rsp;
  assign acc_rsp        = mem_rsp;
  assign host_rsp_valid = mem_rsp_valid && !head_acc;
  assign acc_rsp_valid  = mem_rsp_valid && head_acc;
  assign mem_rsp_ready  = head_acc ? acc_rsp_ready : host_rsp_ready;

  assign rsp_fire = mem_rsp_valid && mem_rsp_ready;

  always_ff @(posedge clk)
    if (req_fire)
      src_q[wr_ptr] <= pick_acc;

  always_ff @(posedge clk)
    if (!sync_rst_n)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end
    else
    begin
      if (req_fire)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rsp_fire)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({req_fire, rsp_fire})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase
    end

  // Memory must not answer a request it never got
  a_rsp_has_owner: assert property (@(posedge clk) disable iff (!sync_rst_n)
    mem_rsp_valid |-> q_count != '0);

  // Count stays within the queue after a push
  a_no_overflow: assert property (@(posedge clk) disable iff (!sync_rst_n)
    req_fire && !rsp_fire |=> q_count != '0 && q_count <= CNT_W'(DEPTH));

endmodule

//--- hw/cl_mem_top.sv
`timescale 1ns/1ps

module cl_mem_top import cl_mem_pkg::*; (
  input  logic     clk,
  input  logic     pipe_rst_n,

  input  mem_req_t host_req,
  input  logic     host_req_valid,
  output logic     host_req_ready,
  output mem_rsp_t host_rsp,
  output logic     host_rsp_valid,
  input  logic     host_rsp_ready,

  input  mem_req_t acc_req,
  input  logic     acc_req_valid,
  output logic     acc_req_ready,
  output mem_rsp_t acc_rsp,
  output logic     acc_rsp_valid,
  input  logic     acc_rsp_ready,

  output mem_req_t mem_req,
  output logic     mem_req_valid,
  input  logic     mem_req_ready,
  input  mem_rsp_t mem_rsp,
  input  logic     mem_rsp_valid,
  output logic     mem_rsp_ready,

  input  logic     flr_assert,
  output logic     flr_done
);

  logic     sync_rst_n;

  // Host side, between slices and arbiter
  mem_req_t hreq;
  logic     hreq_valid;
  logic     hreq_ready;
  mem_rsp_t hrsp;
  logic     hrsp_valid;
  logic     hrsp_ready;

  // Memory side, between arbiter and slices
  mem_req_t mreq;
  logic     mreq_valid;
  logic     mreq_ready;
  mem_rsp_t mrsp;
  logic     mrsp_valid;
  logic     mrsp_ready;

  cl_reset_flr i_reset_flr (
    .clk        (clk),
    .pipe_rst_n (pipe_rst_n),
    .flr_assert (flr_assert),
    .sync_rst_n (sync_rst_n),
    .flr_done   (flr_done)
  );

  //------------------------------
  // Host slices
  //------------------------------
  cl_reg_slice #(.chan_t(mem_req_t)) host_req_slice (
    .clk       (clk),
    .sync_rst_n(sync_rst_n),
    .in_data   (host_req),
    .in_valid  (host_req_valid),
    .in_ready  (host_req_ready),
    .out_data  (hreq),
    .out_valid (hreq_valid),
    .out_ready (hreq_ready)
  );

  cl_reg_slice #(.chan_t(mem_rsp_t)) host_rsp_slice (
    .clk       (clk),
    .sync_rst_n(sync_rst_n),
    .in_data   (hrsp),
    .in_valid  (hrsp_valid),
    .in_ready  (hrsp_ready),
    .out_data  (host_rsp),
    .out_valid (host_rsp_valid),
    .out_ready (host_rsp_ready)
  );

  // Accelerator enters without a slice
  cl_mem_arbiter i_arbiter (
    .clk            (clk),
    .sync_rst_n     (sync_rst_n),
    .host_req       (hreq),
    .host_req_valid (hreq_valid),
    .host_req_ready (hreq_ready),
    .host_rsp       (hrsp),
    .host_rsp_valid (hrsp_valid),
    .host_rsp_ready (hrsp_ready),
    .acc_req        (acc_req),
    .acc_req_valid  (acc_req_valid),
    .acc_req_ready  (acc_req_ready),
    .acc_rsp        (acc_rsp),
    .acc_rsp_valid  (acc_rsp_valid),
    .acc_rsp_ready  (acc_rsp_ready),
    .mem_req        (mreq),
    .mem_req_valid  (mreq_valid),
    .mem_req_ready  (mreq_ready),
    .mem_rsp        (mrsp),
    .mem_rsp_valid  (mrsp_valid),
    .mem_rsp_ready  (mrsp_ready)
  );

  //------------------------------
  // Memory slices
  //------------------------------
  cl_reg_slice #(.chan_t(mem_req_t)) mem_req_slice (
    .clk       (clk),
    .sync_rst_n(sync_rst_n),
    .in_data   (mreq),
    .in_valid  (mreq_valid),
    .in_ready  (mreq_ready),
    .out_data  (mem_req),
    .out_valid (mem_req_valid),
    .out_ready (mem_req_ready)
  );

  cl_reg_slice #(.chan_t(mem_rsp_t)) mem_rsp_slice (
    .clk       (clk),
    .sync_rst_n(sync_rst_n),
    .in_data   (mem_rsp),
    .in_valid  (mem_rsp_valid),
    .in_ready  (mem_rsp_ready),
    .out_data  (mrsp),
    .out_valid (mrsp_valid),
    .out_ready (mrsp_ready)
  );

endmodule

//--- tests/tb_cl_checks.svh
`ifndef TB_CL_CHECKS_SVH
`define TB_CL_CHECKS_SVH

// 32-bit xorshift, shift triple 13/17/5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// ------------------------------
// Compare tasks
// ------------------------------

// Full response word, data and code together
task automatic check_rsp(input string name, input mem_rsp_t got, input mem_rsp_t exp);
  if (got !== exp)
  begin
    $display("[ERROR] t=%0t %s got rdata=%h resp=%0d expected rdata=%h resp=%0d",
             $time, name, got.rdata, got.resp, exp.rdata, exp.resp);
    end_with_failure();
  end
endtask

// Single control bit
task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp)
  begin
    $display("[ERROR] t=%0t %s got %b expected %b", $time, name, got, exp);
    end_with_failure();
  end
endtask

// Queue must hold an expected entry before a response is checked
task automatic check_expected(input string name, input int depth);
  if (depth == 0)
  begin
    $display("Response on %s arrived with no request outstanding", name);
    end_with_failure();
  end
endtask

`endif

//--- tests/tb_cl_mem_top.sv
`timescale 1ns/1ps
`include "cl_consts.svh"

module tb_cl_mem_top import cl_mem_pkg::*; ();

  localparam int CLK_PERIOD      = 4;
  localparam int N_TXN           = 200;
  localparam int N_TOTAL         = 2 * N_TXN;
  // Reset and FLR phases need a few dozen cycles on top
  localparam int WATCHDOG_CYCLES = N_TOTAL * 40 + 64;

  logic     clk = 1'b0;
  logic     pipe_rst_n;
  mem_req_t host_req;
  logic     host_req_valid;
  logic     host_req_ready;
  mem_rsp_t host_rsp;
  logic     host_rsp_valid;
  logic     host_rsp_ready;
  mem_req_t acc_req;
  logic     acc_req_valid;
  logic     acc_req_ready;
  mem_rsp_t acc_rsp;
  logic     acc_rsp_valid;
  logic     acc_rsp_ready;
  mem_req_t mem_req;
  logic     mem_req_valid;
  logic     mem_req_ready;
  mem_rsp_t mem_rsp;
  logic     mem_rsp_valid;
  logic     mem_rsp_ready;
  logic     flr_assert;
  logic     flr_done;

  logic [31:0] rng_state;
  // Scoreboard model, updated when a requester's request is accepted
  logic [31:0] model_mem [logic [15:0]];
  // Memory behind the DUT, updated when mem_req transfers
  logic [31:0] store_mem [logic [15:0]];
  mem_rsp_t    host_exp[$];
  mem_rsp_t    acc_exp[$];
  mem_rsp_t    resp_q[$];
  int          delay_q[$];
  int          host_issued;
  int          acc_issued;
  int          host_done;
  int          acc_done;

  `include "tb_cl_checks.svh"

  always #(CLK_PERIOD / 2) clk = ~clk;

  cl_mem_top i_dut (
    .clk            (clk),
    .pipe_rst_n     (pipe_rst_n),
    .host_req       (host_req),
    .host_req_valid (host_req_valid),
    .host_req_ready (host_req_ready),
    .host_rsp       (host_rsp),
    .host_rsp_valid (host_rsp_valid),
    .host_rsp_ready (host_rsp_ready),
    .acc_req        (acc_req),
    .acc_req_valid  (acc_req_valid),
    .acc_req_ready  (acc_req_ready),
    .acc_rsp        (acc_rsp),
    .acc_rsp_valid  (acc_rsp_valid),
    .acc_rsp_ready  (acc_rsp_ready),
    .mem_req        (mem_req),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_rsp        (mem_rsp),
    .mem_rsp_valid  (mem_rsp_valid),
    .mem_rsp_ready  (mem_rsp_ready),
    .flr_assert     (flr_assert),
    .flr_done       (flr_done)
  );

  task automatic end_with_failure();
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles, host got %0d and accelerator got %0d responses",
             WATCHDOG_CYCLES, host_done, acc_done);
    end_with_failure();
  end

  task automatic draw_rand(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // Byte lanes replaced where the strobe is set
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [`CL_STRB_W-1:0] wstrb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < `CL_STRB_W; b++)
      if (wstrb[b])
        res[8*b +: 8] = wdata[8*b +: 8];
    return res;
  endfunction

  // Top address bit selects the requester, so the two never overlap
  task automatic make_req(input logic src, output mem_req_t r);
    logic [31:0] a;
    logic [31:0] d;
    draw_rand(a);
    draw_rand(d);
    r.write = a[0];
    r.addr  = {src, 9'd0, a[5:2], 2'b00};
    r.wdata = d;
    r.wstrb = a[11:8];
  endtask

  task automatic issue_to_model(input mem_req_t r, output mem_rsp_t exp);
    logic [31:0] old;
    old = model_mem.exists(r.addr) ? model_mem[r.addr] : 32'h0;
    exp.resp = `CL_RESP_OKAY;
    if (r.write)
    begin
      model_mem[r.addr] = merge_bytes(old, r.wdata, r.wstrb);
      exp.rdata = '0;
    end
    else
      exp.rdata = old;
  endtask

  // Memory responder, in order, 0 to 3 cycles of extra delay
  task automatic accept_mem_req(input mem_req_t r);
    logic [31:0] old;
    logic [31:0] d;
    mem_rsp_t    rsp;
    draw_rand(d);
    old = store_mem.exists(r.addr) ? store_mem[r.addr] : 32'h0;
    rsp.resp = `CL_RESP_OKAY;
    if (r.write)
    begin
      store_mem[r.addr] = merge_bytes(old, r.wdata, r.wstrb);
      rsp.rdata = '0;
    end
    else
      rsp.rdata = old;
    resp_q.push_back(rsp);
    delay_q.push_back(int'(d[1:0]));
  endtask

  task automatic check_after_reset();
    repeat (4)
    begin
      @(negedge clk);
      check_bit("host_rsp_valid", host_rsp_valid, 1'b0);
      check_bit("acc_rsp_valid", acc_rsp_valid, 1'b0);
      check_bit("mem_req_valid", mem_req_valid, 1'b0);
      check_bit("flr_done", flr_done, 1'b0);
    end
  endtask

  // Held for 6 cycles, done pulses 2, 4 and 6 cycles after the rise
  task automatic check_flr_pulses();
    @(posedge clk);
    #1;
    flr_assert = 1'b1;
    for (int k = 1; k <= 10; k++)
    begin
      @(posedge clk);
      #1;
      if (k == 6)
        flr_assert = 1'b0;
      @(negedge clk);
      check_bit("flr_done", flr_done, (k == 2) || (k == 4) || (k == 6));
    end
  endtask

  // ------------------------------
  // Random traffic with back-pressure
  // ------------------------------
  task automatic run_traffic();
    logic        h_req_fire;
    logic        a_req_fire;
    logic        m_req_fire;
    logic        m_rsp_fire;
    logic        h_rsp_fire;
    logic        a_rsp_fire;
    mem_req_t    m_req_seen;
    mem_rsp_t    h_rsp_seen;
    mem_rsp_t    a_rsp_seen;
    mem_rsp_t    exp;
    logic [31:0] r;
    while (host_done < N_TXN || acc_done < N_TXN)
    begin
      // Handshakes as the next rising edge will see them
      @(negedge clk);
      h_req_fire = host_req_valid && host_req_ready;
      a_req_fire = acc_req_valid && acc_req_ready;
      m_req_fire = mem_req_valid && mem_req_ready;
      m_rsp_fire = mem_rsp_valid && mem_rsp_ready;
      h_rsp_fire = host_rsp_valid && host_rsp_ready;
      a_rsp_fire = acc_rsp_valid && acc_rsp_ready;
      m_req_seen = mem_req;
      h_rsp_seen = host_rsp;
      a_rsp_seen = acc_rsp;
      @(posedge clk);
      #1;
      if (h_req_fire)
      begin
        issue_to_model(host_req, exp);
        host_exp.push_back(exp);
        host_issued++;
        host_req_valid = 1'b0;
      end
      if (a_req_fire)
      begin
        issue_to_model(acc_req, exp);
        acc_exp.push_back(exp);
        acc_issued++;
        acc_req_valid = 1'b0;
      end
      if (h_rsp_fire)
      begin
        check_expected("host_rsp", host_exp.size());
        check_rsp("host_rsp", h_rsp_seen, host_exp.pop_front());
        host_done++;
      end
      if (a_rsp_fire)
      begin
        check_expected("acc_rsp", acc_exp.size());
        check_rsp("acc_rsp", a_rsp_seen, acc_exp.pop_front());
        acc_done++;
      end
      if (m_rsp_fire)
      begin
        void'(resp_q.pop_front());
        void'(delay_q.pop_front());
      end
      if (delay_q.size() > 0 && delay_q[0] > 0)
        delay_q[0] = delay_q[0] - 1;
      if (m_req_fire)
        accept_mem_req(m_req_seen);

      draw_rand(r);
      if (!host_req_valid && host_issued < N_TXN && r[1:0] != 2'b00)
      begin
        make_req(1'b0, host_req);
        host_req_valid = 1'b1;
      end
      if (!acc_req_valid && acc_issued < N_TXN && r[3:2] != 2'b00)
      begin
        make_req(1'b1, acc_req);
        acc_req_valid = 1'b1;
      end
      host_rsp_ready = |r[5:4];
      acc_rsp_ready  = |r[7:6];
      mem_req_ready  = |r[9:8];
      mem_rsp_valid  = (delay_q.size() > 0) && (delay_q[0] == 0);
      mem_rsp        = (resp_q.size() > 0) ? resp_q[0] : '0;
    end
    if (host_exp.size() != 0 || acc_exp.size() != 0 || resp_q.size() != 0)
    begin
      $display("Traffic ended with responses still queued");
      end_with_failure();
    end
  endtask

  initial
  begin
    rng_state      = 32'd44985;
    pipe_rst_n     = 1'b0;
    host_req       = '0;
    host_req_valid = 1'b0;
    host_rsp_ready = 1'b0;
    acc_req        = '0;
    acc_req_valid  = 1'b0;
    acc_rsp_ready  = 1'b0;
    mem_req_ready  = 1'b0;
    mem_rsp        = '0;
    mem_rsp_valid  = 1'b0;
    flr_assert     = 1'b0;
    host_issued    = 0;
    acc_issued     = 0;
    host_done      = 0;
    acc_done       = 0;
    repeat (8) @(posedge clk);
    #1;
    pipe_rst_n = 1'b1;
    check_after_reset();
    check_flr_pulses();
    run_traffic();
    $display("No errors");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+hw
+incdir+tests
hw/cl_mem_pkg.sv
hw/cl_reset_flr.sv
hw/cl_reg_slice.sv
hw/cl_mem_arbiter.sv
hw/cl_mem_top.sv
tests/tb_cl_mem_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

top=tb_cl_mem_top
build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -f verilog.f --top-module "$top" \
  -o "V${top}" > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  cat "$build_log"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/V${top} > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

if grep -q "Errors found" "$sim_log"; then
  echo "Simulation FAILED"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

echo "Simulation PASSED"
exit 0
